//--- include/blk_cipher_params.svh
`ifndef BLK_CIPHER_PARAMS_SVH
`define BLK_CIPHER_PARAMS_SVH

// Bus and block geometry
`define BUS_W         32
`define BLK_W         128
`define WORDS_PER_BLK 4

// Keyed permutation
`define NUM_ROUNDS    4
`define ROUND_CONST   128'h9e3779b9_7f4a7c15_f39cc060_5cedc834

// Buffering, in blocks
`define IN_FIFO_DEPTH  2
`define OUT_FIFO_DEPTH 4

`endif

//--- hw/blk_cipher_pkg.sv
`include "blk_cipher_params.svh"

package blk_cipher_pkg;

	// Mode field, bits 1:0 of the command word
	typedef enum logic [1:0] {
		mode_ecb = 2'd0,
		mode_cbc = 2'd1,
		mode_ctr = 2'd2
	} mode_op_e;

	typedef struct packed {
		mode_op_e mode;
		logic     decrypt;
	} cmd_t;

	// One block with its end of message tag
	typedef struct packed {
		logic [`BLK_W-1:0] data;
		logic              last;
	} blk_t;

	typedef enum logic [2:0] {
		ctl_cmd,
		ctl_key,
		ctl_iv,
		ctl_run,
		ctl_wait,
		ctl_flush
	} ctl_state_e;

endpackage

//--- hw/bus_block_packer.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module bus_block_packer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`BUS_W-1:0]    in_data,
	input  logic                 in_wren,
	input  logic                 in_last,
	output logic                 in_busy,
	output blk_cipher_pkg::blk_t in_blk,
	output blk_cipher_pkg::cmd_t in_cmd,
	output logic                 in_avail,
	input  logic                 in_take
);
	import blk_cipher_pkg::*;

	localparam int DEPTH = `IN_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int IDX_W = $clog2(`WORDS_PER_BLK);

	logic                     expect_cmd;
	logic [IDX_W-1:0]         word_cnt;
	logic [`BLK_W-`BUS_W-1:0] partial;
	logic                     push;

	blk_t                     fifo_mem [DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;

	// Fourth data word of a block completes it
	assign push = in_wren && !expect_cmd && (word_cnt == IDX_W'(`WORDS_PER_BLK - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			expect_cmd <= 1'b1;
			word_cnt   <= '0;
		end else if (in_wren) begin
			if (expect_cmd) begin
				expect_cmd <= 1'b0;
			end else begin
				word_cnt <= word_cnt + 1'b1;
				if (push && in_last)
					expect_cmd <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_wren && expect_cmd)
			in_cmd <= '{mode: mode_op_e'(in_data[1:0]), decrypt: in_data[4]};
		if (in_wren && !expect_cmd)
			partial <= {partial[`BLK_W-2*`BUS_W-1:0], in_data};
		if (push)
			fifo_mem[wr_ptr] <= '{data: {partial, in_data}, last: in_last};
	end

	// ========================================
	// Block FIFO

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (in_take)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(in_take);
		end
	end

	assign in_blk   = fifo_mem[rd_ptr];
	assign in_avail = (count != '0);
	assign in_busy  = (count == CNT_W'(DEPTH));

endmodule

//--- hw/cipher_core.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module cipher_core (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic              decrypt,
	input  logic [`BLK_W-1:0] key,
	input  logic [`BLK_W-1:0] blk_in,
	output logic              done,
	output logic [`BLK_W-1:0] blk_out
);

	localparam int RND_W = $clog2(`NUM_ROUNDS);
	localparam logic [`BLK_W-1:0] RC = `ROUND_CONST;

	logic              busy;
	logic [RND_W-1:0]  rnd;
	logic              dec_r;
	logic [`BLK_W-1:0] key_r;
	logic [`BLK_W-1:0] state_r;

	logic [RND_W-1:0]  rnd_now;
	logic [RND_W-1:0]  rk_idx;
	logic              dec_now;
	logic [`BLK_W-1:0] key_now;
	logic [`BLK_W-1:0] x_now;
	logic [`BLK_W-1:0] rk;
	logic [`BLK_W-1:0] mix;
	logic [`BLK_W-1:0] y;

	// Round key r is the key rotated left by r words
	function automatic logic [`BLK_W-1:0] rotl_words(input logic [`BLK_W-1:0] k,
			input logic [RND_W-1:0] r);
		logic [2*`BLK_W-1:0] dbl;
		dbl = {k, k} << (r * `BUS_W);
		return dbl[2*`BLK_W-1:`BLK_W];
	endfunction

	// First round works straight from the start inputs
	always_comb begin
		rnd_now = start ? '0 : rnd;
		dec_now = start ? decrypt : dec_r;
		key_now = start ? key : key_r;
		x_now   = start ? blk_in : state_r;
		rk_idx  = dec_now ? RND_W'(`NUM_ROUNDS - 1) - rnd_now : rnd_now;
		rk      = rotl_words(key_now, rk_idx);
		if (dec_now) begin
			mix = x_now - RC;
			mix = {mix[7:0], mix[`BLK_W-1:8]};
			y   = mix ^ rk;
		end else begin
			mix = x_now ^ rk;
			mix = {mix[`BLK_W-9:0], mix[`BLK_W-1:`BLK_W-8]};
			y   = mix + RC;
		end
	end

	always_ff @(posedge clk) begin
		if (start || busy) begin
			state_r <= y;
			key_r   <= key_now;
			dec_r   <= dec_now;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			rnd  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start || busy) begin
				if (rnd_now == RND_W'(`NUM_ROUNDS - 1)) begin
					busy <= 1'b0;
					rnd  <= '0;
					done <= 1'b1;
				end else begin
					busy <= 1'b1;
					rnd  <= rnd_now + 1'b1;
				end
			end
		end
	end

	assign blk_out = state_r;

endmodule

//--- hw/mode_controller.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module mode_controller (
	input  logic                 clk,
	input  logic                 reset,
	input  blk_cipher_pkg::blk_t in_blk,
	input  blk_cipher_pkg::cmd_t in_cmd,
	input  logic                 in_avail,
	output logic                 in_take,
	output logic                 core_start,
	output logic                 core_decrypt,
	output logic [`BLK_W-1:0]    core_key,
	output logic [`BLK_W-1:0]    core_blk,
	input  logic                 core_done,
	input  logic [`BLK_W-1:0]    core_out,
	output blk_cipher_pkg::blk_t res_blk,
	output logic                 res_wr,
	input  logic                 res_room
);
	import blk_cipher_pkg::*;

	ctl_state_e        state;
	cmd_t              cmd_r;
	logic [`BLK_W-1:0] key_r;
	logic [`BLK_W-1:0] iv_r;
	logic [`BLK_W-1:0] saved_r;
	logic              last_r;

	logic              take_key;
	logic              take_iv;
	logic              take_data;
	logic              finish;
	logic [`BLK_W-1:0] pre_blk;
	logic [`BLK_W-1:0] post_data;
	logic [`BLK_W-1:0] iv_next;

	assign take_key  = (state == ctl_key) && in_avail;
	assign take_iv   = (state == ctl_iv) && in_avail;
	// Start only with an output entry free for the result
	assign take_data = (state == ctl_run) && in_avail && res_room;
	assign finish    = (state == ctl_wait) && core_done;
	assign in_take   = take_key || take_iv || take_data;

	// CTR always runs the core forward
	assign core_decrypt = cmd_r.decrypt && (cmd_r.mode != mode_ctr);
	assign core_key     = key_r;

	// ========================================
	// Chaining around the core

	always_comb begin
		pre_blk   = in_blk.data;
		post_data = core_out;
		iv_next   = iv_r;
		case (cmd_r.mode)
			mode_cbc: begin
				if (cmd_r.decrypt) begin
					post_data = core_out ^ iv_r;
					iv_next   = saved_r;
				end else begin
					pre_blk = in_blk.data ^ iv_r;
					iv_next = core_out;
				end
			end
			mode_ctr: begin
				pre_blk   = iv_r;
				post_data = saved_r ^ core_out;
				iv_next   = iv_r + 1'b1;
			end
			default: ;
		endcase
	end

	// ========================================
	// Sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ctl_cmd;
			core_start <= 1'b0;
			res_wr     <= 1'b0;
			last_r     <= 1'b0;
		end else begin
			core_start <= 1'b0;
			res_wr     <= 1'b0;
			case (state)
				ctl_cmd:
					if (in_avail)
						state <= ctl_key;
				ctl_key:
					if (take_key)
						state <= (cmd_r.mode == mode_ecb) ? ctl_run : ctl_iv;
				ctl_iv:
					if (take_iv)
						state <= ctl_run;
				ctl_run:
					if (take_data) begin
						core_start <= 1'b1;
						last_r     <= in_blk.last;
						state      <= ctl_wait;
					end
				ctl_wait:
					if (finish) begin
						res_wr <= 1'b1;
						state  <= last_r ? ctl_flush : ctl_run;
					end
				// Last result goes out this cycle
				ctl_flush:
					state <= ctl_cmd;
				default:
					state <= ctl_cmd;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		// Key block is at the head, so the command is already captured
		if ((state == ctl_cmd) && in_avail)
			cmd_r <= in_cmd;
		if (take_key)
			key_r <= in_blk.data;
		if (take_iv)
			iv_r <= in_blk.data;
		else if (finish)
			iv_r <= iv_next;
		if (take_data) begin
			core_blk <= pre_blk;
			saved_r  <= in_blk.data;
		end
		if (finish)
			res_blk <= '{data: post_data, last: last_r};
	end

endmodule

//--- hw/block_serializer.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module block_serializer (
	input  logic                 clk,
	input  logic                 reset,
	input  blk_cipher_pkg::blk_t res_blk,
	input  logic                 res_wr,
	output logic                 res_room,
	output logic [`BUS_W-1:0]    out_data,
	output logic                 out_valid,
	output logic                 out_last,
	input  logic                 out_ready
);
	import blk_cipher_pkg::*;

	localparam int DEPTH = `OUT_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int IDX_W = $clog2(`WORDS_PER_BLK);

	blk_t             fifo_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] used;
	logic [IDX_W-1:0] word_idx;
	blk_t             head;
	logic             xfer;
	logic             pop;

	always_ff @(posedge clk) begin
		if (res_wr)
			fifo_mem[wr_ptr] <= res_blk;
	end

	// Pending write counts as used
	assign used     = count + CNT_W'(res_wr);
	assign res_room = (used < CNT_W'(DEPTH));

	assign head      = fifo_mem[rd_ptr];
	assign out_valid = (count != '0);
	assign out_data  = head.data[`BLK_W-1 - word_idx*`BUS_W -: `BUS_W];
	assign out_last  = out_valid && head.last
		&& (word_idx == IDX_W'(`WORDS_PER_BLK - 1));

	assign xfer = out_valid && out_ready;
	assign pop  = xfer && (word_idx == IDX_W'(`WORDS_PER_BLK - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			word_idx <= '0;
		end else begin
			if (res_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Index wraps to the next block on the fourth word
			if (xfer)
				word_idx <= word_idx + 1'b1;
			count <= count + CNT_W'(res_wr) - CNT_W'(pop);
		end
	end

endmodule

//--- hw/blk_cipher_top.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module blk_cipher_top (
	input  logic              clk,
	input  logic              reset,
	input  logic [`BUS_W-1:0] in_data,
	input  logic              in_wren,
	input  logic              in_last,
	output logic              in_busy,
	output logic [`BUS_W-1:0] out_data,
	output logic              out_valid,
	output logic              out_last,
	input  logic              out_ready
);
	import blk_cipher_pkg::*;

	blk_t              in_blk;
	cmd_t              in_cmd;
	logic              in_avail;
	logic              in_take;
	logic              core_start;
	logic              core_decrypt;
	logic [`BLK_W-1:0] core_key;
	logic [`BLK_W-1:0] core_blk;
	logic              core_done;
	logic [`BLK_W-1:0] core_out;
	blk_t              res_blk;
	logic              res_wr;
	logic              res_room;

	// ========================================
	// Input side and controller

	bus_block_packer u_packer (
		.clk      (clk),
		.reset    (reset),
		.in_data  (in_data),
		.in_wren  (in_wren),
		.in_last  (in_last),
		.in_busy  (in_busy),
		.in_blk   (in_blk),
		.in_cmd   (in_cmd),
		.in_avail (in_avail),
		.in_take  (in_take)
	);

	mode_controller u_ctl (
		.clk          (clk),
		.reset        (reset),
		.in_blk       (in_blk),
		.in_cmd       (in_cmd),
		.in_avail     (in_avail),
		.in_take      (in_take),
		.core_start   (core_start),
		.core_decrypt (core_decrypt),
		.core_key     (core_key),
		.core_blk     (core_blk),
		.core_done    (core_done),
		.core_out     (core_out),
		.res_blk      (res_blk),
		.res_wr       (res_wr),
		.res_room     (res_room)
	);

	cipher_core u_core (
		.clk     (clk),
		.reset   (reset),
		.start   (core_start),
		.decrypt (core_decrypt),
		.key     (core_key),
		.blk_in  (core_blk),
		.done    (core_done),
		.blk_out (core_out)
	);

	// ========================================
	// Output side

	block_serializer u_ser (
		.clk       (clk),
		.reset     (reset),
		.res_blk   (res_blk),
		.res_wr    (res_wr),
		.res_room  (res_room),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_ready (out_ready)
	);

endmodule

//--- verif/blk_cipher_checker.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module blk_cipher_checker (
	input logic              clk,
	input logic              reset,
	input logic [`BUS_W-1:0] out_data,
	input logic              out_valid,
	input logic              out_last,
	input logic              out_ready,
	input logic              core_start,
	input logic              core_done
);

	int fail_cnt = 0;

	// Word held while the sink stalls
	hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
	else begin
		fail_cnt++;
		$error("output word changed while out_ready was low");
	end

	core_latency_fwd: assert property (@(posedge clk) disable iff (reset)
		core_start |-> ##(`NUM_ROUNDS) core_done)
	else begin
		fail_cnt++;
		$error("core_done missing 4 cycles after core_start");
	end

	core_latency_back: assert property (@(posedge clk) disable iff (reset)
		core_done |-> $past(core_start, `NUM_ROUNDS))
	else begin
		fail_cnt++;
		$error("core_done without core_start 4 cycles earlier");
	end

	// Sync reset clears the output FIFO on the next edge
	quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
	else begin
		fail_cnt++;
		$error("out_valid high after a reset cycle");
	end

endmodule

bind blk_cipher_top blk_cipher_checker u_chk (
	.clk        (clk),
	.reset      (reset),
	.out_data   (out_data),
	.out_valid  (out_valid),
	.out_last   (out_last),
	.out_ready  (out_ready),
	.core_start (core_start),
	.core_done  (core_done)
);

//--- verif/blk_cipher_tb.sv
`timescale 1ns/1ps
`include "blk_cipher_params.svh"

module blk_cipher_tb;
	import blk_cipher_pkg::*;

	typedef logic [`BLK_W-1:0] blk_queue_t [$];

	// Data blocks over all tests
	localparam int BLOCKS_SENT = 27;
	localparam int CYCLE_LIMIT = 200 * BLOCKS_SENT + 1000;
	localparam logic [`BLK_W-1:0] RC = `ROUND_CONST;

	logic              clk;
	logic              reset;
	logic [`BUS_W-1:0] in_data;
	logic              in_wren;
	logic              in_last;
	logic              in_busy;
	logic [`BUS_W-1:0] out_data;
	logic              out_valid;
	logic              out_last;
	logic              out_ready;

	logic [15:0]       lfsr_state;
	logic              bp_on;
	logic              busy_seen;
	int                errors;
	int                check_cnt;
	int                cycle_cnt;

	logic [`BUS_W-1:0] rx_word_q [$];
	logic              rx_last_q [$];
	logic [`BLK_W-1:0] exp_blk_q [$];
	logic              exp_last_q [$];

	blk_cipher_top DUT (
		.clk       (clk),
		.reset     (reset),
		.in_data   (in_data),
		.in_wren   (in_wren),
		.in_last   (in_last),
		.in_busy   (in_busy),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Random source and reference model

	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [`BLK_W-1:0] rand_blk();
		logic [`BLK_W-1:0] v;
		for (int i = 0; i < `BLK_W; i++)
			v = {v[`BLK_W-2:0], next_rand_bit()};
		return v;
	endfunction

	function automatic blk_queue_t rand_blocks(input int n);
		blk_queue_t q;
		for (int i = 0; i < n; i++)
			q.push_back(rand_blk());
		return q;
	endfunction

	function automatic logic [`BLK_W-1:0] rotate_left(input logic [`BLK_W-1:0] v, input int n);
		return (v << n) | (v >> (`BLK_W - n));
	endfunction

	function automatic logic [`BLK_W-1:0] model_encrypt(input logic [`BLK_W-1:0] p,
			input logic [`BLK_W-1:0] key);
		logic [`BLK_W-1:0] x;
		x = p;
		for (int r = 0; r < `NUM_ROUNDS; r++) begin
			x = x ^ rotate_left(key, `BUS_W * r);
			x = rotate_left(x, 8);
			x = x + RC;
		end
		return x;
	endfunction

	function automatic logic [`BLK_W-1:0] model_decrypt(input logic [`BLK_W-1:0] c,
			input logic [`BLK_W-1:0] key);
		logic [`BLK_W-1:0] x;
		x = c;
		for (int r = `NUM_ROUNDS - 1; r >= 0; r--) begin
			x = x - RC;
			x = rotate_left(x, `BLK_W - 8);
			x = x ^ rotate_left(key, `BUS_W * r);
		end
		return x;
	endfunction

	function automatic blk_queue_t model_mode(input mode_op_e mode, input logic dec,
			input logic [`BLK_W-1:0] key, input logic [`BLK_W-1:0] iv, input blk_queue_t din);
		blk_queue_t dout;
		logic [`BLK_W-1:0] chain;
		logic [`BLK_W-1:0] r;
		chain = iv;
		foreach (din[i]) begin
			case (mode)
				mode_cbc: begin
					if (dec) begin
						r = model_decrypt(din[i], key) ^ chain;
						chain = din[i];
					end else begin
						r = model_encrypt(din[i] ^ chain, key);
						chain = r;
					end
				end
				mode_ctr: begin
					r = din[i] ^ model_encrypt(chain, key);
					chain = chain + 1'b1;
				end
				default: r = dec ? model_decrypt(din[i], key) : model_encrypt(din[i], key);
			endcase
			dout.push_back(r);
		end
		return dout;
	endfunction

	// ========================================
	// Stimulus, receiver and compares

	task automatic write_word(input logic [`BUS_W-1:0] w, input logic last);
		while (in_busy) begin
			@(posedge clk);
			#1;
		end
		in_data = w;
		in_last = last;
		in_wren = 1'b1;
		@(posedge clk);
		#1;
		in_wren = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic send_block(input logic [`BLK_W-1:0] b, input logic last);
		for (int i = 0; i < `WORDS_PER_BLK; i++)
			write_word(b[`BLK_W-1 - i*`BUS_W -: `BUS_W], last && (i == `WORDS_PER_BLK - 1));
	endtask

	task automatic send_msg(input mode_op_e mode, input logic dec,
			input logic [`BLK_W-1:0] key, input logic [`BLK_W-1:0] iv, input blk_queue_t blks);
		write_word({27'd0, dec, 2'b00, mode}, 1'b0);
		send_block(key, 1'b0);
		if (mode != mode_ecb)
			send_block(iv, 1'b0);
		foreach (blks[i])
			send_block(blks[i], i == blks.size() - 1);
	endtask

	task automatic expect_blocks(input blk_queue_t blks);
		foreach (blks[i]) begin
			exp_blk_q.push_back(blks[i]);
			exp_last_q.push_back(i == blks.size() - 1);
		end
	endtask

	always @(negedge clk) begin
		if (!reset && out_valid && out_ready) begin
			rx_word_q.push_back(out_data);
			rx_last_q.push_back(out_last);
		end
	end

	// Input side should push back once blocks pile up
	always @(negedge clk) begin
		if (bp_on && in_busy)
			busy_seen = 1'b1;
	end

	always @(posedge clk) begin
		logic bp_now;
		bp_now = bp_on;
		#1;
		out_ready = bp_now ? next_rand_bit() : 1'b1;
	end

	task automatic check_blk(input logic [`BLK_W-1:0] got, input logic [`BLK_W-1:0] exp,
			input string what);
		check_cnt++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s block got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s out_last got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic drain_and_compare(input string what);
		logic [`BLK_W-1:0] got;
		logic [`BLK_W-1:0] exp;
		logic              exp_last;
		while (rx_word_q.size() < `WORDS_PER_BLK * exp_blk_q.size()) begin
			@(posedge clk);
			#1;
		end
		while (exp_blk_q.size() > 0) begin
			exp = exp_blk_q.pop_front();
			exp_last = exp_last_q.pop_front();
			for (int j = 0; j < `WORDS_PER_BLK; j++) begin
				got = {got[`BLK_W-`BUS_W-1:0], rx_word_q.pop_front()};
				check_last(rx_last_q.pop_front(), exp_last && (j == `WORDS_PER_BLK - 1), what);
			end
			check_blk(got, exp, what);
		end
		// Nothing more may follow
		repeat (20) @(posedge clk);
		#1;
		if (rx_word_q.size() != 0) begin
			errors++;
			$display("%s produced %0d output words more than expected", what, rx_word_q.size());
			rx_word_q.delete();
			rx_last_q.delete();
		end
	endtask

	// ========================================
	// Directed tests

	task automatic test_ecb_encrypt();
		logic [`BLK_W-1:0] key;
		blk_queue_t        pt;
		key = rand_blk();
		pt = rand_blocks(3);
		expect_blocks(model_mode(mode_ecb, 1'b0, key, '0, pt));
		send_msg(mode_ecb, 1'b0, key, '0, pt);
		drain_and_compare("ECB encrypt");
	endtask

	task automatic test_ecb_decrypt();
		logic [`BLK_W-1:0] key;
		blk_queue_t        pt;
		key = rand_blk();
		pt = rand_blocks(3);
		expect_blocks(pt);
		send_msg(mode_ecb, 1'b1, key, '0, model_mode(mode_ecb, 1'b0, key, '0, pt));
		drain_and_compare("ECB decrypt");
	endtask

	task automatic test_cbc_round_trip();
		logic [`BLK_W-1:0] key;
		logic [`BLK_W-1:0] iv;
		blk_queue_t        pt;
		blk_queue_t        ct;
		key = rand_blk();
		iv = rand_blk();
		pt = rand_blocks(3);
		ct = model_mode(mode_cbc, 1'b0, key, iv, pt);
		expect_blocks(ct);
		send_msg(mode_cbc, 1'b0, key, iv, pt);
		drain_and_compare("CBC encrypt");
		expect_blocks(pt);
		send_msg(mode_cbc, 1'b1, key, iv, ct);
		drain_and_compare("CBC decrypt");
	endtask

	task automatic test_ctr_carry();
		logic [`BLK_W-1:0] key;
		logic [`BLK_W-1:0] iv;
		blk_queue_t        pt;
		key = rand_blk();
		iv = rand_blk();
		// Low word all ones so the first increment carries upward
		iv[`BUS_W-1:0] = '1;
		pt = rand_blocks(4);
		expect_blocks(model_mode(mode_ctr, 1'b0, key, iv, pt));
		send_msg(mode_ctr, 1'b0, key, iv, pt);
		drain_and_compare("CTR carry");
	endtask

	task automatic test_back_pressure();
		logic [`BLK_W-1:0] key;
		blk_queue_t        pt;
		key = rand_blk();
		pt = rand_blocks(6);
		expect_blocks(model_mode(mode_ecb, 1'b0, key, '0, pt));
		busy_seen = 1'b0;
		bp_on = 1'b1;
		send_msg(mode_ecb, 1'b0, key, '0, pt);
		drain_and_compare("ECB back-pressure");
		check_cnt++;
		if (!busy_seen) begin
			errors++;
			$display("in_busy never went high while the output was back-pressured");
		end
		bp_on = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic test_back_to_back();
		logic [`BLK_W-1:0] key_a;
		logic [`BLK_W-1:0] iv_a;
		logic [`BLK_W-1:0] key_b;
		logic [`BLK_W-1:0] iv_b;
		blk_queue_t        pt_a;
		blk_queue_t        pt_b;
		key_a = rand_blk();
		iv_a = rand_blk();
		key_b = rand_blk();
		iv_b = rand_blk();
		pt_a = rand_blocks(2);
		pt_b = rand_blocks(3);
		expect_blocks(model_mode(mode_ctr, 1'b1, key_a, iv_a, pt_a));
		expect_blocks(model_mode(mode_cbc, 1'b0, key_b, iv_b, pt_b));
		// CTR ignores the decrypt bit
		send_msg(mode_ctr, 1'b1, key_a, iv_a, pt_a);
		send_msg(mode_cbc, 1'b0, key_b, iv_b, pt_b);
		drain_and_compare("CTR then CBC");
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, expected output never arrived", CYCLE_LIMIT);
		$display("Checks: %0d, errors: %0d", check_cnt, errors + 1);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		in_data = '0;
		in_wren = 1'b0;
		in_last = 1'b0;
		out_ready = 1'b0;
		lfsr_state = 16'd64877;
		bp_on = 1'b0;
		busy_seen = 1'b0;
		errors = 0;
		check_cnt = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		test_ecb_encrypt();
		test_ecb_decrypt();
		test_cbc_round_trip();
		test_ctr_carry();
		test_back_pressure();
		test_back_to_back();
		errors += DUT.u_chk.fail_cnt;
		$display("Checks: %0d, errors: %0d (assertion failures: %0d)", check_cnt, errors,
			DUT.u_chk.fail_cnt);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+include
hw/blk_cipher_pkg.sv
hw/bus_block_packer.sv
hw/cipher_core.sv
hw/mode_controller.sv
hw/block_serializer.sv
hw/blk_cipher_top.sv
verif/blk_cipher_checker.sv
verif/blk_cipher_tb.sv

//--- Bender.yml
package:
  name: blk_cipher

export_include_dirs:
  - include

sources:
  - files:
      - hw/blk_cipher_pkg.sv
      - hw/bus_block_packer.sv
      - hw/cipher_core.sv
      - hw/mode_controller.sv
      - hw/block_serializer.sv
      - hw/blk_cipher_top.sv
  - target: test
    files:
      - verif/blk_cipher_checker.sv
      - verif/blk_cipher_tb.sv
